// File: src.f
logic/chip_pkg.sv
logic/tag_client.sv
logic/link_downstream.sv
logic/core_offset.sv
logic/link_upstream.sv
logic/chip_block.sv
verification/tb_clock.sv
verification/chip_block_checker.sv
verification/chip_block_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the chip block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module chip_block_tb \
  --Mdir obj_dir -o chip_block_sim

./obj_dir/chip_block_sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation passed"

// File: verification/chip_block_tb.sv
/* Testbench top with DUT, far-end link model, tag frames,
   LFSR stimulus, watchdog and tests */

module chip_block_tb
  import chip_pkg::*;
  ();

  localparam int TEST_WORDS     = 4 + 40 + 8 + 8 + 8 + 30;
  localparam int TIMEOUT_CYCLES = TEST_WORDS * 20 + 400;

  logic clk;
  logic arst_n;
  logic tag_en;
  logic tag_data;
  logic in_v;
  logic [LINK_WIDTH-1:0] in_data;
  logic in_token;
  logic out_v;
  logic [LINK_WIDTH-1:0] out_data;
  logic out_token = 1'b0;
  logic hold_tokens;
  logic [TAG_PAYLOAD_BITS-1:0] model_offset;
  logic [15:0] lfsr_state;
  int tokens_got   = 0;
  int words_sent   = 0;
  int words_seen   = 0;
  int tokens_given = 0;
  int test_errors  = 0;
  int pending;
  int words_out;
  int value_errors;
  int protocol_errors;

  tb_clock clock (.clk_o(clk), .arst_n_o(arst_n));

  chip_block DUT
  (.clk_i        (clk      )
  ,.arst_n_i     (arst_n   )
  ,.tag_en_i     (tag_en   )
  ,.tag_data_i   (tag_data )
  ,.link_v_i     (in_v     )
  ,.link_data_i  (in_data  )
  ,.link_token_o (in_token )
  ,.link_v_o     (out_v    )
  ,.link_data_o  (out_data )
  ,.link_token_i (out_token)
  );

  chip_block_checker monitor
  (.clk_i (clk), .arst_n_i (arst_n), .offset_i (model_offset)
  ,.in_v_i (in_v), .in_data_i (in_data), .in_token_i (in_token)
  ,.out_v_i (out_v), .out_data_i (out_data), .out_token_i (out_token)
  ,.pending_o (pending), .words_out_o (words_out)
  ,.value_errors_o (value_errors), .protocol_errors_o (protocol_errors)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [LINK_WIDTH-1:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits = {bits[LINK_WIDTH-2:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  ////////////////////////////////////////
  // Far end of both links
  ////////////////////////////////////////

  always @(posedge clk)
    if (arst_n && in_token)
      tokens_got++;

  always @(posedge clk)
    if (arst_n && out_v)
      words_seen++;

  // One token back per word received, unless held
  always @(negedge clk)
  begin
    out_token = 1'b0;
    if (!hold_tokens && words_seen > tokens_given)
    begin
      out_token = 1'b1;
      tokens_given++;
    end
  end

  task automatic send_word(input logic [LINK_WIDTH-1:0] data);
    while (LINK_CREDITS + tokens_got - words_sent <= 0)
      @(negedge clk);
    in_v    = 1'b1;
    in_data = data;
    words_sent++;
    @(negedge clk);
    in_v = 1'b0;
  endtask

  task automatic send_random(input int count);
    logic [LINK_WIDTH-1:0] data;
    repeat (count)
    begin
      take_bits(LINK_WIDTH, data);
      send_word(data);
    end
  endtask

  // Start bit, id and payload, LSB first
  task automatic send_frame
    (input logic [TAG_ID_BITS-1:0] id, input tag_payload_u payload, input logic enable);
    logic [TAG_FRAME_BITS:0] frame;
    frame = {payload, id, 1'b1};
    for (int i = 0; i <= TAG_FRAME_BITS; i++)
    begin
      tag_en   = enable;
      tag_data = frame[i];
      @(negedge clk);
    end
    tag_en   = 1'b0;
    tag_data = 1'b0;
  endtask

  task automatic set_enable(input logic enable);
    tag_payload_u payload;
    payload             = '0;
    payload.link.enable = enable;
    send_frame(TAG_NODE_LINK, payload, 1'b1);
  endtask

  task automatic set_offset(input logic [TAG_PAYLOAD_BITS-1:0] offset, input logic tag_enable);
    tag_payload_u payload;
    payload.offset = offset;
    send_frame(TAG_NODE_CORE, payload, tag_enable);
    repeat (2) @(negedge clk);
    if (tag_enable)
      model_offset = offset;
  endtask

  task automatic drain();
    while (pending != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic finish_run(input logic timed_out);
    $display("Errors: value %0d, protocol %0d, test %0d, timeout %0d",
             value_errors, protocol_errors, test_errors, timed_out);
    if (timed_out || (value_errors + protocol_errors + test_errors) != 0)
      $display("Test FAILED");
    else
      $display("Test OK");
    $finish;
  endtask

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles", TIMEOUT_CYCLES);
    finish_run(1'b1);
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial
  begin
    int base;
    int stop_base;
    logic [LINK_WIDTH-1:0] data;
    tag_en       = 1'b0;
    tag_data     = 1'b0;
    in_v         = 1'b0;
    in_data      = '0;
    hold_tokens  = 1'b0;
    model_offset = '0;
    lfsr_state   = 16'd95;
    wait (arst_n);
    @(negedge clk);

    // Nothing leaves before the link is enabled
    send_random(4);
    repeat (10) @(negedge clk);
    if (words_out != 0)
    begin
      $display("%0d words left the output link before it was enabled", words_out);
      test_errors++;
    end
    set_enable(1'b1);
    drain();

    set_offset(8'h3C, 1'b1);
    send_random(40);
    drain();

    // Sums wrap near the top of the range
    set_offset(8'hFF, 1'b1);
    send_word(16'hFFFF);
    send_word(16'hFF01);
    repeat (6)
    begin
      take_bits(8, data);
      send_word({8'hFF, data[7:0]});
    end
    drain();

    // Output credits run out while tokens are held
    hold_tokens = 1'b1;
    base = words_out;
    send_random(8);
    repeat (20) @(negedge clk);
    if (words_out - base != LINK_CREDITS)
    begin
      $display("%0d words sent with tokens held, credits are %0d", words_out - base, LINK_CREDITS);
      test_errors++;
    end
    hold_tokens = 1'b0;
    drain();

    // Core frame ignored with the tag line disabled
    set_offset(8'h5A, 1'b0);
    send_random(8);
    drain();

    // Link disabled in the middle of a stream
    base = words_sent;
    fork
      send_random(30);
      begin
        wait (words_sent >= base + 5);
        set_enable(1'b0);
        stop_base = words_out;
        repeat (20) @(negedge clk);
        if (words_out - stop_base > 3)
        begin
          $display("%0d words left after the link was disabled", words_out - stop_base);
          test_errors++;
        end
        set_enable(1'b1);
      end
    join
    drain();
    finish_run(1'b0);
  end

endmodule

// File: verification/chip_block_checker.sv
/* Link watcher with the reference model, expected word queue,
   credit checks and error counts */

module chip_block_checker
  import chip_pkg::*;
  (input  logic                        clk_i
  ,input  logic                        arst_n_i
  ,input  logic                        in_v_i
  ,input  logic [LINK_WIDTH-1:0]       in_data_i
  ,input  logic                        in_token_i
  ,input  logic                        out_v_i
  ,input  logic [LINK_WIDTH-1:0]       out_data_i
  ,input  logic                        out_token_i
  ,input  logic [TAG_PAYLOAD_BITS-1:0] offset_i
  ,output int                          pending_o
  ,output int                          words_out_o
  ,output int                          value_errors_o
  ,output int                          protocol_errors_o
  );

  logic [LINK_WIDTH-1:0] expected_q [$];
  logic [LINK_WIDTH-1:0] expected;
  int in_outstanding  = 0;
  int out_outstanding = 0;
  int words_out       = 0;
  int value_errors    = 0;
  int protocol_errors = 0;

  // Input word plus offset, wrapped at the word width
  function automatic logic [LINK_WIDTH-1:0] reference_word
    (input logic [LINK_WIDTH-1:0] data, input logic [TAG_PAYLOAD_BITS-1:0] offset);
    int sum;
    sum = int'(data) + int'(offset);
    return LINK_WIDTH'(sum % 65536);
  endfunction

  always @(posedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (in_v_i)
        expected_q.push_back(reference_word(in_data_i, offset_i));
      in_outstanding += int'(in_v_i) - int'(in_token_i);
      if (in_outstanding > LINK_CREDITS || in_outstanding < 0)
      begin
        $display("%0t: input link has %0d words outstanding, credits are %0d",
                 $time, in_outstanding, LINK_CREDITS);
        protocol_errors++;
      end
      if (out_v_i)
      begin
        words_out++;
        if (expected_q.size() == 0)
        begin
          $display("%0t: output link sent %h while no word was expected", $time, out_data_i);
          protocol_errors++;
        end
        else
        begin
          expected = expected_q.pop_front();
          if (out_data_i !== expected)
          begin
            $display("ERROR %0t link_data_o: got %h, expected %h", $time, out_data_i, expected);
            value_errors++;
          end
        end
      end
      // Words on the output link not yet paid back by a token
      out_outstanding += int'(out_v_i) - int'(out_token_i);
      if (out_outstanding > LINK_CREDITS)
      begin
        $display("%0t: output link sent %0d words against %0d credits",
                 $time, out_outstanding, LINK_CREDITS);
        protocol_errors++;
      end
    end
  end

  assign pending_o         = expected_q.size();
  assign words_out_o       = words_out;
  assign value_errors_o    = value_errors;
  assign protocol_errors_o = protocol_errors;

endmodule

// File: verification/tb_clock.sv
/* Testbench clock and reset generator */

module tb_clock
  (output logic clk_o
  ,output logic arst_n_o
  );

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 3;

  initial
  begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    fork
      forever #HALF_PERIOD clk_o = ~clk_o;
      begin
        // Release away from the rising edge
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o) arst_n_o = 1'b1;
      end
    join
  end

endmodule

// File: logic/chip_block.sv
/* Chip block top: tag gating, tag client, input link, core stage
   and output link on one clock */

module chip_block
  import chip_pkg::*;
  (input  logic                  clk_i
  ,input  logic                  arst_n_i

  ,input  logic                  tag_en_i
  ,input  logic                  tag_data_i

  ,input  logic                  link_v_i
  ,input  logic [LINK_WIDTH-1:0] link_data_i
  ,output logic                  link_token_o

  ,output logic                  link_v_o
  ,output logic [LINK_WIDTH-1:0] link_data_o
  ,input  logic                  link_token_i
  );

  ////////////////////////////////////////
  // Tag
  ////////////////////////////////////////

  logic                        tag_data_lo;
  logic                        link_enable;
  logic [TAG_PAYLOAD_BITS-1:0] offset_lo;

  // Bits sent with enable low read as zero
  assign tag_data_lo = tag_en_i & tag_data_i;

  tag_client tag
  (.clk_i         (clk_i      )
  ,.arst_n_i      (arst_n_i   )
  ,.tag_data_i    (tag_data_lo)
  ,.link_enable_o (link_enable)
  ,.core_offset_o (offset_lo  )
  );

  ////////////////////////////////////////
  // Input link
  ////////////////////////////////////////

  logic                  rx_valid;
  logic [LINK_WIDTH-1:0] rx_data;
  logic                  rx_ready;

  link_downstream link_in
  (.clk_i        (clk_i       )
  ,.arst_n_i     (arst_n_i    )
  ,.link_v_i     (link_v_i    )
  ,.link_data_i  (link_data_i )
  ,.link_token_o (link_token_o)
  ,.rx_valid_o   (rx_valid    )
  ,.rx_data_o    (rx_data     )
  ,.rx_ready_i   (rx_ready    )
  );

  ////////////////////////////////////////
  // Core complex
  ////////////////////////////////////////

  logic                  tx_valid;
  logic [LINK_WIDTH-1:0] tx_data;
  logic                  tx_ready;

  core_offset core
  (.clk_i      (clk_i      )
  ,.arst_n_i   (arst_n_i   )
  ,.enable_i   (link_enable)
  ,.offset_i   (offset_lo  )
  ,.rx_valid_i (rx_valid   )
  ,.rx_data_i  (rx_data    )
  ,.rx_ready_o (rx_ready   )
  ,.tx_valid_o (tx_valid   )
  ,.tx_data_o  (tx_data    )
  ,.tx_ready_i (tx_ready   )
  );

  ////////////////////////////////////////
  // Output link
  ////////////////////////////////////////

  link_upstream link_out
  (.clk_i        (clk_i       )
  ,.arst_n_i     (arst_n_i    )
  ,.tx_valid_i   (tx_valid    )
  ,.tx_data_i    (tx_data     )
  ,.tx_ready_o   (tx_ready    )
  ,.link_v_o     (link_v_o    )
  ,.link_data_o  (link_data_o )
  ,.link_token_i (link_token_i)
  );

endmodule

// File: logic/link_upstream.sv
/* Output link sender with output register and credit counter */

module link_upstream
  import chip_pkg::*;
  (input  logic                  clk_i
  ,input  logic                  arst_n_i

  // From the core
  ,input  logic                  tx_valid_i
  ,input  logic [LINK_WIDTH-1:0] tx_data_i
  ,output logic                  tx_ready_o

  // Off-chip side
  ,output logic                  link_v_o
  ,output logic [LINK_WIDTH-1:0] link_data_o
  ,input  logic                  link_token_i
  );

  logic [LINK_CNT_BITS-1:0] credits_r;
  logic                     v_r;
  logic [LINK_WIDTH-1:0]    data_r;
  logic                     send;

  // Each word is on the link for one cycle, so the register is
  // always free again; only credits hold the core back
  assign tx_ready_o = (credits_r != '0);
  assign send       = tx_valid_i && tx_ready_o;

  ////////////////////////////////////////
  // Credits
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      credits_r <= LINK_CNT_BITS'(LINK_CREDITS);
    else
      credits_r <= credits_r + LINK_CNT_BITS'(link_token_i) - LINK_CNT_BITS'(send);
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      v_r <= 1'b0;
    else
      v_r <= send;
  end

  always_ff @(posedge clk_i)
  begin
    if (send)
      data_r <= tx_data_i;
  end

  assign link_v_o    = v_r;
  assign link_data_o = data_r;

endmodule

// File: logic/core_offset.sv
/* Core stage that adds the tag offset to each word */

module core_offset
  import chip_pkg::*;
  (input  logic                        clk_i
  ,input  logic                        arst_n_i
  ,input  logic                        enable_i
  ,input  logic [TAG_PAYLOAD_BITS-1:0] offset_i

  ,input  logic                        rx_valid_i
  ,input  logic [LINK_WIDTH-1:0]       rx_data_i
  ,output logic                        rx_ready_o

  ,output logic                        tx_valid_o
  ,output logic [LINK_WIDTH-1:0]       tx_data_o
  ,input  logic                        tx_ready_i
  );

  logic                  full_r;
  logic [LINK_WIDTH-1:0] data_r;
  logic                  take;

  // Disabled stage still drains, it just stops taking
  assign rx_ready_o = enable_i && (!full_r || tx_ready_i);
  assign take       = rx_valid_i && rx_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      full_r <= 1'b0;
    else if (take)
      full_r <= 1'b1;
    else if (tx_ready_i)
      full_r <= 1'b0;
  end

  // Sum wraps at the word width
  always_ff @(posedge clk_i)
  begin
    if (take)
      data_r <= rx_data_i + LINK_WIDTH'(offset_i);
  end

  assign tx_valid_o = full_r;
  assign tx_data_o  = data_r;

endmodule

// File: logic/link_downstream.sv
/* Input link receiver, credit-sized buffer and token return */

module link_downstream
  import chip_pkg::*;
  (input  logic                  clk_i
  ,input  logic                  arst_n_i

  // Off-chip side
  ,input  logic                  link_v_i
  ,input  logic [LINK_WIDTH-1:0] link_data_i
  ,output logic                  link_token_o

  // Toward the core
  ,output logic                  rx_valid_o
  ,output logic [LINK_WIDTH-1:0] rx_data_o
  ,input  logic                  rx_ready_i
  );

  logic [LINK_WIDTH-1:0]    mem_r [LINK_CREDITS];
  logic [LINK_PTR_BITS-1:0] wr_ptr_r;
  logic [LINK_PTR_BITS-1:0] rd_ptr_r;
  logic [LINK_CNT_BITS-1:0] count_r;
  logic                     token_r;

  logic                     wr_fire;
  logic                     rd_fire;

  // Far end only sends while it holds a credit
  assign wr_fire = link_v_i;
  assign rd_fire = rx_valid_o && rx_ready_i;

  ////////////////////////////////////////
  // Buffer
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (wr_fire)
      mem_r[wr_ptr_r] <= link_data_i;
  end

  // Pointers wrap at the power-of-two depth
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (wr_fire)
        wr_ptr_r <= wr_ptr_r + LINK_PTR_BITS'(1);
      if (rd_fire)
        rd_ptr_r <= rd_ptr_r + LINK_PTR_BITS'(1);
      count_r <= count_r + LINK_CNT_BITS'(wr_fire) - LINK_CNT_BITS'(rd_fire);
    end
  end

  assign rx_valid_o = (count_r != '0);
  assign rx_data_o  = mem_r[rd_ptr_r];

  ////////////////////////////////////////
  // Token return
  ////////////////////////////////////////

  // One pulse per word drained
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      token_r <= 1'b0;
    else
      token_r <= rd_fire;
  end

  assign link_token_o = token_r;

endmodule

// File: logic/tag_client.sv
/* Serial tag frame receiver with the link enable and core offset
   registers */

module tag_client
  import chip_pkg::*;
  (input  logic                        clk_i
  ,input  logic                        arst_n_i
  ,input  logic                        tag_data_i
  ,output logic                        link_enable_o
  ,output logic [TAG_PAYLOAD_BITS-1:0] core_offset_o
  );

  logic                      busy_r;
  logic [TAG_CNT_BITS-1:0]   bit_cnt_r;
  logic [TAG_FRAME_BITS-1:0] shift_r;
  logic                      done_r;
  logic                      last_bit;

  logic [TAG_ID_BITS-1:0]    frame_id;
  tag_payload_u              frame_payload;

  logic                      enable_r;
  logic [TAG_PAYLOAD_BITS-1:0] offset_r;

  assign last_bit = busy_r && (bit_cnt_r == TAG_CNT_BITS'(TAG_FRAME_BITS - 1));

  ////////////////////////////////////////
  // Frame capture
  ////////////////////////////////////////

  // A one while idle is the start bit
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r    <= 1'b0;
      bit_cnt_r <= '0;
      done_r    <= 1'b0;
    end
    else
    begin
      done_r <= last_bit;
      if (!busy_r)
      begin
        busy_r    <= tag_data_i;
        bit_cnt_r <= '0;
      end
      else
      begin
        bit_cnt_r <= bit_cnt_r + TAG_CNT_BITS'(1);
        if (last_bit)
          busy_r <= 1'b0;
      end
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk_i)
  begin
    if (busy_r)
      shift_r <= {tag_data_i, shift_r[TAG_FRAME_BITS-1:1]};
  end

  ////////////////////////////////////////
  // Node decode
  ////////////////////////////////////////

  assign frame_id      = shift_r[TAG_ID_BITS-1:0];
  assign frame_payload = shift_r[TAG_FRAME_BITS-1:TAG_ID_BITS];

  // Unknown ids are dropped here
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      enable_r <= 1'b0;
      offset_r <= '0;
    end
    else if (done_r)
    begin
      if (frame_id == TAG_NODE_LINK)
        enable_r <= frame_payload.link.enable;
      else if (frame_id == TAG_NODE_CORE)
        offset_r <= frame_payload.offset;
    end
  end

  assign link_enable_o = enable_r;
  assign core_offset_o = offset_r;

endmodule

// File: logic/chip_pkg.sv
/* Link, credit and tag constants shared by the chip block,
   plus the tag payload union decoded by the link and core nodes */

package chip_pkg;

  ////////////////////////////////////////
  // Link
  ////////////////////////////////////////

  localparam int LINK_WIDTH   = 16;

  // Tokens per link direction, also the receive buffer depth
  localparam int LINK_CREDITS = 4;

  localparam int LINK_PTR_BITS = $clog2(LINK_CREDITS);
  localparam int LINK_CNT_BITS = $clog2(LINK_CREDITS + 1);

  ////////////////////////////////////////
  // Tag
  ////////////////////////////////////////

  localparam int TAG_ID_BITS      = 2;
  localparam int TAG_PAYLOAD_BITS = 8;

  // Id and payload bits that follow the start bit
  localparam int TAG_FRAME_BITS = TAG_ID_BITS + TAG_PAYLOAD_BITS;
  localparam int TAG_CNT_BITS   = $clog2(TAG_FRAME_BITS);

  localparam logic [TAG_ID_BITS-1:0] TAG_NODE_LINK = TAG_ID_BITS'(0);
  localparam logic [TAG_ID_BITS-1:0] TAG_NODE_CORE = TAG_ID_BITS'(1);

  // Link node view
  typedef struct packed {
    logic [TAG_PAYLOAD_BITS-2:0] reserved;
    logic                        enable;
  } tag_link_s;

  // One payload word, read per node
  typedef union packed {
    tag_link_s                   link;
    logic [TAG_PAYLOAD_BITS-1:0] offset;
  } tag_payload_u;

endpackage
